/* vectrex_board.f */
logic/vectrex_board_pkg.sv
logic/reset_sequencer.sv
logic/control_mapper.sv
logic/video_overlay.sv
logic/cart_store.sv
logic/audio_dac.sv
logic/vectrex_board.sv
verification/vectrex_board_asserts.sv
verification/vectrex_board_tb.sv

/* Bender.yml */
package:
  name: vectrex_board

sources:
  - files:
      - logic/vectrex_board_pkg.sv
      - logic/reset_sequencer.sv
      - logic/control_mapper.sv
      - logic/video_overlay.sv
      - logic/cart_store.sv
      - logic/audio_dac.sv
      - logic/vectrex_board.sv
  - target: test
    files:
      - verification/vectrex_board_asserts.sv
      - verification/vectrex_board_tb.sv

/* verification/vectrex_board_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vectrex_board_tb;

	localparam int LOGO_DELAY     = 2000;
	localparam int HOLD           = vectrex_board_pkg::RESET_HOLD_CYCLES;
	localparam int TIMEOUT_CYCLES = 20000; // About twice the whole sequence

	logic clk_24, reset_start, menu_button, download, load_wr, cart_req;
	logic hblank, vblank, frame_line;
	logic [31:0] status;
	logic [14:0] load_addr, cart_addr;
	logic [7:0]  load_data, joystick_0, joystick_1;
	logic [15:0] joy_ana_0, joy_ana_1;
	logic [3:0]  core_r, core_g, core_b;
	logic [9:0]  core_audio;
	wire core_reset, cpu_alt, speech_mode, cart_ack, audio_bit, led;
	wire [3:0] btn1, btn2, video_r, video_g, video_b;
	wire [7:0] pot_x_1, pot_y_1, pot_x_2, pot_y_2, cart_data;

	logic [31:0] lfsr = 32'h28cec90b;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	logic [7:0] cart_model [0:(2 ** vectrex_board_pkg::CART_ADDR_W)-1];

	vectrex_board #(.logo_delay(LOGO_DELAY)) i_vectrex_board (.*);

	initial begin
		clk_24 = 1'b0;
		forever #10 clk_24 = ~clk_24;
	end

	always @(posedge clk_24) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // x^32+x^22+x^2+x+1
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("failure: %s", what);
	endtask

	task automatic step_to_sample();
		@(posedge clk_24);
		@(negedge clk_24); // Outputs settled here
	endtask

	task automatic measure_reset(output int delay, output int width);
		delay = 0;
		width = 0;
		do begin
			step_to_sample();
			delay++;
		end while (!core_reset && delay < 16);
		while (core_reset && width <= HOLD + 8) begin
			width++;
			step_to_sample();
		end
	endtask

	task automatic wait_ack(input logic level, input string what, output int cycles);
		cycles = 0;
		do begin
			step_to_sample();
			cycles++;
		end while (cart_ack !== level && cycles < 16);
		if (cart_ack !== level)
			report_failure(what);
	endtask

	task automatic cart_read(input logic [14:0] addr, input logic stall);
		int cycles;
		@(posedge clk_24);
		cart_req  <= 1'b1;
		cart_addr <= addr;
		if (stall) begin
			repeat (6) begin
				step_to_sample();
				check_value("cart_ack", cart_ack, 1'b0);
				check_value("led", led, 1'b0);
			end
			@(posedge clk_24);
			download <= 1'b0; // Latency counts from here
		end
		wait_ack(1'b1, "no acknowledge for a cartridge read", cycles);
		check_value("cart_ack latency", cycles, vectrex_board_pkg::ACK_LATENCY);
		check_value("cart_data", cart_data, cart_model[addr]);
		@(posedge clk_24);
		cart_req <= 1'b0;
		wait_ack(1'b0, "cart_ack stayed high after cart_req fell", cycles);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic verify_reset_length();
		int delay;
		int width;
		repeat (5) @(posedge clk_24);
		reset_start <= 1'b0;
		measure_reset(delay, width);
		check_value("core_reset width after reset_start", width, HOLD);
		@(posedge clk_24);
		menu_button <= 1'b1;
		@(posedge clk_24);
		menu_button <= 1'b0;
		measure_reset(delay, width);
		check_value("core_reset delay", delay, 2); // Register, counter load, output
		check_value("core_reset width after menu_button", width, HOLD);
	endtask

	task automatic load_and_read_cart();
		logic [14:0] addrs [64];
		logic [7:0]  data;
		@(posedge clk_24);
		download <= 1'b1;
		for (int i = 0; i < 64; i++) begin
			addrs[i] = take_bits(15);
			data = take_bits(8);
			cart_model[addrs[i]] = data;
			@(posedge clk_24);
			load_wr   <= 1'b1;
			load_addr <= addrs[i];
			load_data <= data;
		end
		@(posedge clk_24);
		load_wr <= 1'b0;
		cart_read(addrs[0], 1'b1);
		check_value("led", led, 1'b1);
		for (int i = 1; i < 64; i++)
			cart_read(addrs[i], 1'b0);
	endtask

	task automatic verify_logo_skip(input logic keep);
		int n;
		logic seen_low;
		@(posedge clk_24);
		status[vectrex_board_pkg::STATUS_KEEP_LOGO] <= keep;
		download <= 1'b1;
		repeat (4) @(posedge clk_24);
		download <= 1'b0;
		n = 0;
		seen_low = 1'b0;
		while (n < 2 * LOGO_DELAY && !(seen_low && core_reset)) begin
			step_to_sample();
			n++;
			seen_low |= !core_reset;
		end
		if (keep && core_reset)
			report_failure("core_reset high again although the logo was kept");
		if (!keep)
			check_value("logo-skip core_reset delay", n, LOGO_DELAY + 3);
	endtask

	task automatic map_controllers();
		logic [7:0]  j0, j1, p1, p2, y1, y2;
		logic [15:0] a0, a1, q1, q2;
		for (int i = 0; i < 16; i++) begin
			j0 = take_bits(8);
			j1 = take_bits(8);
			a0 = take_bits(16);
			a1 = take_bits(16);
			@(posedge clk_24);
			status[vectrex_board_pkg::STATUS_SWAP_PORTS] <= i[3];
			joystick_0 <= j0;
			joystick_1 <= j1;
			joy_ana_0  <= a0;
			joy_ana_1  <= a1;
			step_to_sample();
			p1 = i[3] ? j1 : j0;
			p2 = i[3] ? j0 : j1;
			q1 = i[3] ? a1 : a0;
			q2 = i[3] ? a0 : a1;
			y1 = ~q1[7:0]; // Y byte flipped for the console
			y2 = ~q2[7:0];
			check_value("btn1", btn1, p1[7:4]);
			check_value("btn2", btn2, p2[7:4]);
			check_value("pot_x_1", pot_x_1, q1[15:8]);
			check_value("pot_y_1", pot_y_1, y1);
			check_value("pot_x_2", pot_x_2, q2[15:8]);
			check_value("pot_y_2", pot_y_2, y2);
		end
	endtask

	task automatic overlay_video();
		logic [11:0] rgb;
		logic [11:0] expected;
		logic [3:0]  ctl;
		for (int i = 0; i < 32; i++) begin
			rgb = take_bits(12);
			ctl = take_bits(4);
			@(posedge clk_24);
			{core_r, core_g, core_b} <= rgb;
			{frame_line, hblank, vblank} <= ctl[2:0];
			status[vectrex_board_pkg::STATUS_SHOW_FRAME] <= ctl[3];
			status[vectrex_board_pkg::STATUS_CPU_ALT] <= ctl[0];
			status[vectrex_board_pkg::STATUS_SPEECH] <= ctl[1];
			step_to_sample();
			if (ctl[3] && ctl[2])
				expected = 12'h400; // Dark red marker
			else if (ctl[1] || ctl[0])
				expected = '0;
			else
				expected = rgb;
			check_value("video_r/g/b", {video_r, video_g, video_b}, expected);
			check_value("cpu_alt", cpu_alt, ctl[0]);
			check_value("speech_mode", speech_mode, ctl[1]);
		end
	endtask

	task automatic measure_audio_density(input logic [9:0] sample);
		int ones;
		@(posedge clk_24);
		core_audio <= sample;
		@(posedge clk_24);
		ones = 0;
		repeat (1024) begin
			@(negedge clk_24);
			ones += audio_bit;
			@(posedge clk_24);
		end
		check_value("audio_bit high count", ones, sample);
	endtask

	initial begin
		reset_start = 1'b1;
		status = '0;
		{menu_button, download, load_wr, cart_req} = '0;
		{load_addr, load_data, cart_addr} = '0;
		{joystick_0, joystick_1, joy_ana_0, joy_ana_1} = '0;
		{core_r, core_g, core_b, hblank, vblank, frame_line} = '0;
		core_audio = '0;
		verify_reset_length();
		load_and_read_cart();
		verify_logo_skip(1'b0);
		verify_logo_skip(1'b1);
		map_controllers();
		overlay_video();
		measure_audio_density(10'd0);
		measure_audio_density(10'd341);
		measure_audio_density(10'd1023);
		other_errors += i_vectrex_board.i_vectrex_board_asserts.fail_count;
		$display("Wrong values: %0d, other failures: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/vectrex_board_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module vectrex_board_asserts (
	input wire       clk_24,
	input wire       reset_start,
	input wire       download,
	input wire       cart_req,
	input wire       cart_ack,
	input wire [7:0] cart_data
);

	int fail_count = 0; // Failed assertions so far

	ack_needs_req: assert property (@(posedge clk_24) disable iff (reset_start)
		$rose(cart_ack) |-> cart_req)
		else begin
			fail_count++;
			$error("cart_ack rose without cart_req");
		end

	ack_not_in_download: assert property (@(posedge clk_24) disable iff (reset_start)
		$rose(cart_ack) |-> !download)
		else begin
			fail_count++;
			$error("cart_ack rose during a download");
		end

	// Read data held for the whole acknowledge phase
	data_held: assert property (@(posedge clk_24) disable iff (reset_start)
		cart_ack |=> !cart_ack || $stable(cart_data))
		else begin
			fail_count++;
			$error("cart_data changed while cart_ack was high");
		end

endmodule

bind vectrex_board vectrex_board_asserts i_vectrex_board_asserts (
	.clk_24, .reset_start, .download, .cart_req, .cart_ack, .cart_data
);

`default_nettype wire

/* logic/vectrex_board.sv */
`timescale 1ns/1ps
`default_nettype none

module vectrex_board #(
	parameter int logo_delay = 5_000_000
) (
	input  wire                                          clk_24,
	input  wire                                          reset_start,
	input  wire  [vectrex_board_pkg::STATUS_W-1:0]       status,
	input  wire                                          menu_button,
	input  wire                                          download,
	input  wire                                          load_wr,
	input  wire  [vectrex_board_pkg::CART_ADDR_W-1:0]    load_addr,
	input  wire  [7:0]                                   load_data,
	input  wire  [7:0]                                   joystick_0,
	input  wire  [7:0]                                   joystick_1,
	input  wire  [15:0]                                  joy_ana_0,
	input  wire  [15:0]                                  joy_ana_1,
	input  wire                                          cart_req,
	input  wire  [vectrex_board_pkg::CART_ADDR_W-1:0]    cart_addr,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]        core_r,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]        core_g,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]        core_b,
	input  wire                                          hblank,
	input  wire                                          vblank,
	input  wire                                          frame_line,
	input  wire  [vectrex_board_pkg::AUDIO_W-1:0]        core_audio,
	output logic                                         core_reset,
	output logic                                         cpu_alt,
	output logic                                         speech_mode,
	output logic [3:0]                                   btn1,
	output logic [3:0]                                   btn2,
	output logic [7:0]                                   pot_x_1,
	output logic [7:0]                                   pot_y_1,
	output logic [7:0]                                   pot_x_2,
	output logic [7:0]                                   pot_y_2,
	output logic                                         cart_ack,
	output logic [7:0]                                   cart_data,
	output logic [vectrex_board_pkg::COLOR_W-1:0]        video_r,
	output logic [vectrex_board_pkg::COLOR_W-1:0]        video_g,
	output logic [vectrex_board_pkg::COLOR_W-1:0]        video_b,
	output logic                                         audio_bit,
	output logic                                         led
);

	logic swap;
	logic show_frame;

	// Menu options taken straight from the status word
	assign swap        = status[vectrex_board_pkg::STATUS_SWAP_PORTS];
	assign show_frame  = status[vectrex_board_pkg::STATUS_SHOW_FRAME];
	assign cpu_alt     = status[vectrex_board_pkg::STATUS_CPU_ALT];
	assign speech_mode = status[vectrex_board_pkg::STATUS_SPEECH];

	reset_sequencer #(
		.logo_delay (logo_delay)
	) i_reset_sequencer (
		.clk_24, .reset_start, .status, .menu_button, .download, .core_reset
	);

	control_mapper i_control_mapper (
		.clk_24, .reset_start, .swap, .joystick_0, .joystick_1, .joy_ana_0, .joy_ana_1,
		.btn1, .btn2, .pot_x_1, .pot_y_1, .pot_x_2, .pot_y_2
	);

	video_overlay i_video_overlay (
		.clk_24, .reset_start, .show_frame, .frame_line, .hblank, .vblank,
		.core_r, .core_g, .core_b, .video_r, .video_g, .video_b
	);

	cart_store i_cart_store (
		.clk_24, .reset_start, .download, .load_wr, .load_addr, .load_data,
		.cart_req, .cart_addr, .cart_ack, .cart_data, .led
	);

	audio_dac i_audio_dac (
		.clk_24, .reset_start, .core_audio, .audio_bit
	);

endmodule

`default_nettype wire

/* logic/audio_dac.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_dac (
	input  wire                                      clk_24,
	input  wire                                      reset_start,
	input  wire  [vectrex_board_pkg::AUDIO_W-1:0]    core_audio,
	output logic                                     audio_bit
);

	logic [vectrex_board_pkg::AUDIO_W-1:0] acc;
	logic [vectrex_board_pkg::AUDIO_W:0]   sum;

	// First-order modulator, carry is the output density
	assign sum = {1'b0, acc} + {1'b0, core_audio};

	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[vectrex_board_pkg::AUDIO_W-1:0];
			audio_bit <= sum[vectrex_board_pkg::AUDIO_W]; // Carry out
		end
	end

endmodule

`default_nettype wire

/* logic/cart_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_store (
	input  wire                                          clk_24,
	input  wire                                          reset_start,
	input  wire                                          download,
	input  wire                                          load_wr,
	input  wire  [vectrex_board_pkg::CART_ADDR_W-1:0]    load_addr,
	input  wire  [7:0]                                   load_data,
	input  wire                                          cart_req,
	input  wire  [vectrex_board_pkg::CART_ADDR_W-1:0]    cart_addr,
	output logic                                         cart_ack,
	output logic [7:0]                                   cart_data,
	output logic                                         led
);

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_ack
	} state_t;

	state_t state;
	logic [$clog2(vectrex_board_pkg::ACK_LATENCY + 1)-1:0] wait_count;
	logic [7:0] mem [0:(2 ** vectrex_board_pkg::CART_ADDR_W)-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Loader write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_24) begin
		if (download && load_wr)
			mem[load_addr] <= load_data; // One byte per strobe
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Four-phase read handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			state      <= st_idle;
			wait_count <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cart_req && !download) begin // Stalled while loading
						state      <= st_read;
						wait_count <= $bits(wait_count)'(vectrex_board_pkg::ACK_LATENCY - 1);
					end
				end
				st_read: begin
					if (download)
						state <= st_idle; // Loader took over, retry later
					else if (wait_count == 1)
						state <= st_ack;
					else
						wait_count <= wait_count - 1'b1;
				end
				st_ack: begin
					if (!cart_req)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Data is captured once and held through the ack phase
	always_ff @(posedge clk_24) begin
		if (state == st_read && !download && wait_count == 1)
			cart_data <= mem[cart_addr];
	end

	assign cart_ack = (state == st_ack);

	always_ff @(posedge clk_24) begin
		if (reset_start)
			led <= 1'b1;
		else
			led <= ~download;
	end

endmodule

`default_nettype wire

/* logic/video_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module video_overlay (
	input  wire                                      clk_24,
	input  wire                                      reset_start,
	input  wire                                      show_frame,
	input  wire                                      frame_line,
	input  wire                                      hblank,
	input  wire                                      vblank,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]    core_r,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]    core_g,
	input  wire  [vectrex_board_pkg::COLOR_W-1:0]    core_b,
	output logic [vectrex_board_pkg::COLOR_W-1:0]    video_r,
	output logic [vectrex_board_pkg::COLOR_W-1:0]    video_g,
	output logic [vectrex_board_pkg::COLOR_W-1:0]    video_b
);

	logic frame_on;
	logic blank;

	assign frame_on = show_frame & frame_line;
	assign blank    = hblank | vblank;

	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			video_r <= '0;
			video_g <= '0;
			video_b <= '0;
		end else if (frame_on) begin // Marker wins over blanking
			video_r <= vectrex_board_pkg::FRAME_R;
			video_g <= vectrex_board_pkg::FRAME_G;
			video_b <= vectrex_board_pkg::FRAME_B;
		end else begin
			video_r <= blank ? '0 : core_r;
			video_g <= blank ? '0 : core_g;
			video_b <= blank ? '0 : core_b;
		end
	end

endmodule

`default_nettype wire

/* logic/control_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module control_mapper (
	input  wire         clk_24,
	input  wire         reset_start,
	input  wire         swap,
	input  wire  [7:0]  joystick_0,
	input  wire  [7:0]  joystick_1,
	input  wire  [15:0] joy_ana_0,
	input  wire  [15:0] joy_ana_1,
	output logic [3:0]  btn1,
	output logic [3:0]  btn2,
	output logic [7:0]  pot_x_1,
	output logic [7:0]  pot_y_1,
	output logic [7:0]  pot_x_2,
	output logic [7:0]  pot_y_2
);

	logic [7:0]  joy_p1;
	logic [7:0]  joy_p2;
	logic [15:0] ana_p1;
	logic [15:0] ana_p2;

	// Physical controller feeding each console port
	assign joy_p1 = swap ? joystick_1 : joystick_0;
	assign joy_p2 = swap ? joystick_0 : joystick_1;
	assign ana_p1 = swap ? joy_ana_1 : joy_ana_0;
	assign ana_p2 = swap ? joy_ana_0 : joy_ana_1;

	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			btn1    <= '0;
			btn2    <= '0;
			pot_x_1 <= '0;
			pot_y_1 <= '0;
			pot_x_2 <= '0;
			pot_y_2 <= '0;
		end else begin
			btn1    <= joy_p1[7:4]; // Fire buttons
			btn2    <= joy_p2[7:4];
			pot_x_1 <= ana_p1[15:8];
			pot_y_1 <= ~ana_p1[7:0]; // Console Y runs the other way
			pot_x_2 <= ana_p2[15:8];
			pot_y_2 <= ~ana_p2[7:0];
		end
	end

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int logo_delay = 5_000_000
) (
	input  wire                                       clk_24,
	input  wire                                       reset_start,
	input  wire  [vectrex_board_pkg::STATUS_W-1:0]    status,
	input  wire                                       menu_button,
	input  wire                                       download,
	output logic                                      core_reset
);

	logic trigger;
	logic trigger_q;
	logic second_reset;
	logic logo_arm;
	logic [$clog2(vectrex_board_pkg::RESET_HOLD_CYCLES + 1)-1:0] hold_count;
	logic [$clog2(logo_delay + 1)-1:0] logo_timer;

	assign trigger = status[vectrex_board_pkg::STATUS_MENU_RESET]
		| status[vectrex_board_pkg::STATUS_RESET_ITEM]
		| menu_button | download | second_reset;

	assign logo_arm = download & ~status[vectrex_board_pkg::STATUS_KEEP_LOGO];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Core reset stretcher
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			trigger_q  <= 1'b0;
			hold_count <= $bits(hold_count)'(vectrex_board_pkg::RESET_HOLD_CYCLES);
			core_reset <= 1'b1;
		end else begin
			trigger_q  <= trigger;
			core_reset <= (hold_count != '0);
			if (trigger_q)
				hold_count <= $bits(hold_count)'(vectrex_board_pkg::RESET_HOLD_CYCLES);
			else if (hold_count != '0)
				hold_count <= hold_count - 1'b1;
		end
	end

	// Logo timer, rearmed every download cycle
	always_ff @(posedge clk_24) begin
		if (reset_start) begin
			logo_timer   <= '0;
			second_reset <= 1'b0;
		end else begin
			second_reset <= (logo_timer == 1) & ~logo_arm; // Only on the 1 to 0 step
			if (logo_arm)
				logo_timer <= $bits(logo_timer)'(logo_delay);
			else if (logo_timer != '0)
				logo_timer <= logo_timer - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* logic/vectrex_board_pkg.sv */
`default_nettype none

package vectrex_board_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Menu status word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int STATUS_W          = 32;
	localparam int STATUS_MENU_RESET = 0;
	localparam int STATUS_CPU_ALT    = 1;
	localparam int STATUS_SHOW_FRAME = 2;
	localparam int STATUS_KEEP_LOGO  = 3; // Set means no logo-skip reset
	localparam int STATUS_SWAP_PORTS = 4;
	localparam int STATUS_SPEECH     = 5;
	localparam int STATUS_RESET_ITEM = 6;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int COLOR_W           = 4;
	localparam int CART_ADDR_W       = 15; // 32 KiB cartridge space
	localparam int AUDIO_W           = 10;
	localparam int RESET_HOLD_CYCLES = 1000;
	localparam int ACK_LATENCY       = 2; // Req high to ack high

	localparam logic [COLOR_W-1:0] FRAME_R = 4'h4; // Dark red marker
	localparam logic [COLOR_W-1:0] FRAME_G = 4'h0;
	localparam logic [COLOR_W-1:0] FRAME_B = 4'h0;

endpackage

`default_nettype wire
